//--- rtl/rf_pkg.sv
/*
 Shared sizes and types of the integer register file:
 address width, word width, register count and the address and word types.
*/

package rf_pkg;

   // Five address bits select one of the integer registers.
   localparam int RF_ADDR_W = 5;

   // Every register holds one 32-bit machine word.
   localparam int RF_DATA_W = 32;

   // The register count follows from the address width, so the two cannot
   // drift apart.
   localparam int RF_DEPTH = 1 << RF_ADDR_W;

   // A register address as carried on every read and write port.
   typedef logic [RF_ADDR_W-1:0] rf_addr_t;

   // A register word as stored in the RAM and returned on the read ports.
   typedef logic [RF_DATA_W-1:0] rf_data_t;

endpackage : rf_pkg

//--- rtl/rf_dpram.sv
/*
 Single-clock simple dual-port RAM with a registered read port and
 a same-cycle write-to-read bypass.
*/

module rf_dpram (
   input  logic             clk,
   input  rf_pkg::rf_addr_t raddr,
   input  logic             re,
   input  rf_pkg::rf_addr_t waddr,
   input  logic             we,
   input  rf_pkg::rf_data_t din,
   output rf_pkg::rf_data_t dout
);

   import rf_pkg::*;

   // Storage array, one word per register.
   rf_data_t mem [RF_DEPTH];

   // Registered read data, captured on every read strobe.
   rf_data_t rdata;

   // Copy of the write data taken on a read strobe, used when the read hit
   // the address being written on the same edge.
   rf_data_t din_r;

   // Set when the last read collided with a write to the same address.
   logic bypass;

   // The write lands on the edge where we is high.
   // The read samples the array before that write takes effect.
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= din;
      end
      if (re) begin
         rdata <= mem[raddr];
      end
   end

   // The bypass flag and the data copy only move on a read strobe, so the
   // presented value holds until the next read.
   always_ff @(posedge clk) begin
      if (re) begin
         din_r  <= din;
         bypass <= we && (waddr == raddr);
      end
   end

   // The colliding write wins over the stale array word.
   assign dout = bypass ? din_r : rdata;

   // After a colliding read and write, the new data must come out next cycle.
   a_bypass_data : assert property (
      @(posedge clk) (re && we && (waddr == raddr)) |=> (dout === $past(din))
   );

   // A read that does not collide returns the word held before the edge.
   a_plain_read : assert property (
      @(posedge clk) (re && !(we && (waddr == raddr))) |=> (dout === $past(mem[raddr]))
   );

endmodule : rf_dpram

//--- rtl/rf_clear.sv
/*
 Post-reset clear sequencer. It owns the RAM write port, sweeps zeros over
 every register, then forwards external writes and raises ready.
*/

module rf_clear (
   input  logic             clk,
   input  logic             rst,
   input  logic             we,
   input  rf_pkg::rf_addr_t waddr,
   input  rf_pkg::rf_data_t wdata,
   output logic             mem_we,
   output rf_pkg::rf_addr_t mem_waddr,
   output rf_pkg::rf_data_t mem_wdata,
   output logic             ready
);

   import rf_pkg::*;

   // Address of the next zero write in the sweep.
   rf_addr_t clr_addr;

   // High from reset until the last register has been cleared.
   logic busy;

   // The counter steps once per busy cycle and wraps back to zero after the
   // top address, so it rests at zero once the sweep is done.
   // Busy drops on the edge that issues the write to the top address.
   always_ff @(posedge clk) begin
      if (rst) begin
         clr_addr <= '0;
         busy     <= 1'b1;
      end else if (busy) begin
         clr_addr <= clr_addr + 1'b1;
         if (clr_addr == rf_addr_t'(RF_DEPTH - 1)) begin
            busy <= 1'b0;
         end
      end
   end

   // During the sweep the sequencer drives its own zero writes.
   // External writes in that window are simply dropped.
   // Afterwards the external write passes straight through.
   always_comb begin
      if (busy) begin
         mem_we    = 1'b1;
         mem_waddr = clr_addr;
         mem_wdata = '0;
      end else begin
         mem_we    = we;
         mem_waddr = waddr;
         mem_wdata = wdata;
      end
   end

   assign ready = !busy;

   // Ready must not show up while the sweep is part way through the array.
   a_ready_after_sweep : assert property (
      @(posedge clk) disable iff (rst) (clr_addr != '0) |-> !ready
   );

   // The sweep visits consecutive addresses without skipping any.
   a_addr_step : assert property (
      @(posedge clk) disable iff (rst)
         busy |=> (clr_addr == rf_addr_t'($past(clr_addr) + 1'b1))
   );

endmodule : rf_clear

//--- rtl/rf_bank.sv
/*
 Register bank with two read ports built from two RAM copies
 sharing one write port. Register zero always reads as zero.
*/

module rf_bank (
   input  logic             clk,
   input  logic             rst,
   input  logic             we,
   input  rf_pkg::rf_addr_t waddr,
   input  rf_pkg::rf_data_t wdata,
   input  logic             re_a,
   input  rf_pkg::rf_addr_t raddr_a,
   output rf_pkg::rf_data_t rdata_a,
   input  logic             re_b,
   input  rf_pkg::rf_addr_t raddr_b,
   output rf_pkg::rf_data_t rdata_b
);

   import rf_pkg::*;

   // Raw RAM outputs before the register-zero mask.
   rf_data_t dout_a;
   rf_data_t dout_b;

   // Set when the last read on that port addressed register zero.
   logic zero_a;
   logic zero_b;

   // Both copies take every write, so their contents stay identical.
   // Each copy then serves its own read port.
   rf_dpram ram_a (
      .clk   (clk),
      .raddr (raddr_a),
      .re    (re_a),
      .waddr (waddr),
      .we    (we),
      .din   (wdata),
      .dout  (dout_a)
   );

   rf_dpram ram_b (
      .clk   (clk),
      .raddr (raddr_b),
      .re    (re_b),
      .waddr (waddr),
      .we    (we),
      .din   (wdata),
      .dout  (dout_b)
   );

   // The zero flags follow the read strobes, like the RAM read data, so the
   // mask lines up with the word it hides.
   always_ff @(posedge clk) begin
      if (rst) begin
         zero_a <= 1'b0;
         zero_b <= 1'b0;
      end else begin
         if (re_a) begin
            zero_a <= (raddr_a == '0);
         end
         if (re_b) begin
            zero_b <= (raddr_b == '0);
         end
      end
   end

   // Register zero hides whatever was written there, bypass included.
   assign rdata_a = zero_a ? '0 : dout_a;
   assign rdata_b = zero_b ? '0 : dout_b;

   // A read of register zero yields zero on the next cycle on either port.
   a_zero_a : assert property (
      @(posedge clk) disable iff (rst) (re_a && (raddr_a == '0)) |=> (rdata_a == '0)
   );

   a_zero_b : assert property (
      @(posedge clk) disable iff (rst) (re_b && (raddr_b == '0)) |=> (rdata_b == '0)
   );

endmodule : rf_bank

//--- rtl/rf_top.sv
/*
 Register file top level. The clear sequencer feeds the shared write port
 of the two-port register bank.
*/

module rf_top (
   input  logic             clk,
   input  logic             rst,
   output logic             ready,
   input  logic             we,
   input  rf_pkg::rf_addr_t waddr,
   input  rf_pkg::rf_data_t wdata,
   input  logic             re_a,
   input  rf_pkg::rf_addr_t raddr_a,
   output rf_pkg::rf_data_t rdata_a,
   input  logic             re_b,
   input  rf_pkg::rf_addr_t raddr_b,
   output rf_pkg::rf_data_t rdata_b
);

   import rf_pkg::*;

   // Write port as seen by the RAMs, after the clear sequencer.
   logic     mem_we;
   rf_addr_t mem_waddr;
   rf_data_t mem_wdata;

   rf_clear u_clear (
      .clk       (clk),
      .rst       (rst),
      .we        (we),
      .waddr     (waddr),
      .wdata     (wdata),
      .mem_we    (mem_we),
      .mem_waddr (mem_waddr),
      .mem_wdata (mem_wdata),
      .ready     (ready)
   );

   // Reads go straight to the bank. Data is undefined until ready is high.
   rf_bank u_bank (
      .clk     (clk),
      .rst     (rst),
      .we      (mem_we),
      .waddr   (mem_waddr),
      .wdata   (mem_wdata),
      .re_a    (re_a),
      .raddr_a (raddr_a),
      .rdata_a (rdata_a),
      .re_b    (re_b),
      .raddr_b (raddr_b),
      .rdata_b (rdata_b)
   );

endmodule : rf_top

//--- tests/tb_clock.sv
/*
 Free-running testbench clock with a period of 100 time units.
*/

module tb_clock (
   output logic clk
);

   // The clock starts low, so the first rising edge comes at time 50.
   initial begin
      clk = 1'b0;
   end

   // Half a period in each phase.
   always begin
      #50 clk = ~clk;
   end

endmodule : tb_clock

//--- tests/tb_rf.sv
/*
 Testbench top for the register file: clock and reset, LFSR stimulus,
 reference model, concurrent checks on ready and both read ports, reporting.
*/

module tb_rf;

   import rf_pkg::*;

   // Stimulus seed, longest wait for ready in cycles, and random test length.
   localparam logic [31:0] SEED          = 32'h0472210f;
   localparam int          READY_TIMEOUT = 40;
   localparam int          RANDOM_OPS    = 64;

   logic     clk;
   logic     rst;
   logic     ready;
   logic     we;
   rf_addr_t waddr;
   rf_data_t wdata;
   logic     re_a;
   rf_addr_t raddr_a;
   rf_data_t rdata_a;
   logic     re_b;
   rf_addr_t raddr_b;
   rf_data_t rdata_b;

   // Reference model of the register contents and the expected port data.
   rf_data_t model [RF_DEPTH];
   rf_data_t exp_a;
   rf_data_t exp_b;
   // A port is checked only once it has seen a read while ready was high.
   logic     chk_a;
   logic     chk_b;

   // Model of the clear sweep, counting the edges since reset fell.
   int       clr_cnt;
   logic     exp_ready;

   logic [31:0] lfsr;
   int          errors;
   int          checks;
   int          tests_run;
   int          tests_failed;

   tb_clock clock_gen (
      .clk (clk)
   );

   rf_top uut (
      .clk     (clk),
      .rst     (rst),
      .ready   (ready),
      .we      (we),
      .waddr   (waddr),
      .wdata   (wdata),
      .re_a    (re_a),
      .raddr_a (raddr_a),
      .rdata_a (rdata_a),
      .re_b    (re_b),
      .raddr_b (raddr_b),
      .rdata_b (rdata_b)
   );

   // Value a read presents after this edge. Register zero is always zero,
   // a same-edge write to the read address wins, else the old contents.
   function automatic rf_data_t expect_read(rf_addr_t raddr);
      if (raddr == '0) begin
         return '0;
      end
      if (we && exp_ready && (waddr == raddr)) begin
         return wdata;
      end
      return model[raddr];
   endfunction

   // The model follows the DUT edge by edge. Inputs are stable here, and the
   // modelled ready flag still holds its value from before the edge. Writes
   // while not ready are dropped, just as the clear sweep drops them.
   // One zero write goes out per edge after reset, so ready is expected to
   // rise on the edge that issues the write to the top address.
   always @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < RF_DEPTH; i++) begin
            model[i] <= '0;
         end
         chk_a     <= 1'b0;
         chk_b     <= 1'b0;
         clr_cnt   <= 0;
         exp_ready <= 1'b0;
      end else begin
         checks += int'(chk_a) + int'(chk_b);
         if (clr_cnt < RF_DEPTH) begin
            clr_cnt <= clr_cnt + 1;
         end
         if (clr_cnt == RF_DEPTH - 1) begin
            exp_ready <= 1'b1;
         end
         if (re_a) begin
            exp_a <= expect_read(raddr_a);
            chk_a <= exp_ready;
         end
         if (re_b) begin
            exp_b <= expect_read(raddr_b);
            chk_b <= exp_ready;
         end
         if (we && exp_ready) begin
            model[waddr] <= wdata;
         end
      end
   end

   // Ready must follow the sweep exactly, low through the clear and high after.
   ready_timing : assert property (
      @(posedge clk) disable iff (rst) ready === exp_ready
   ) else begin
      errors++;
      $display("FAILED ready: got %h, expected %h", $sampled(ready), $sampled(exp_ready));
   end

   // Each port must show the expected word from the cycle after a read until
   // the next read, so holding is covered as well.
   port_a_data : assert property (
      @(posedge clk) disable iff (rst) chk_a |-> (rdata_a === exp_a)
   ) else begin
      errors++;
      $display("FAILED rdata_a: got %h, expected %h", $sampled(rdata_a), $sampled(exp_a));
   end

   port_b_data : assert property (
      @(posedge clk) disable iff (rst) chk_b |-> (rdata_b === exp_b)
   ) else begin
      errors++;
      $display("FAILED rdata_b: got %h, expected %h", $sampled(rdata_b), $sampled(exp_b));
   end

   // Galois LFSR, stepped once for every bit handed out.
   function automatic logic [31:0] next_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic rand_bit();
      logic [31:0] r;
      r = next_bits(1);
      return r[0];
   endfunction

   function automatic rf_addr_t rand_addr();
      return rf_addr_t'(next_bits(RF_ADDR_W));
   endfunction

   function automatic rf_data_t rand_data();
      return next_bits(RF_DATA_W);
   endfunction

   // Inputs change a small fixed delay after the rising edge.
   task automatic tick();
      @(posedge clk);
      #10;
   endtask

   task automatic idle_inputs();
      we      = 1'b0;
      waddr   = '0;
      wdata   = '0;
      re_a    = 1'b0;
      raddr_a = '0;
      re_b    = 1'b0;
      raddr_b = '0;
   endtask

   task automatic apply_reset();
      idle_inputs();
      rst = 1'b1;
      repeat (5) tick();
      rst = 1'b0;
   endtask

   // Polls ready once per cycle and gives up after READY_TIMEOUT cycles.
   task automatic wait_ready(output bit ok);
      ok = 1'b0;
      for (int i = 0; (i < READY_TIMEOUT) && !ok; i++) begin
         tick();
         ok = ready;
      end
      if (!ok) begin
         errors++;
         $display("Timeout: ready did not rise within %0d cycles", READY_TIMEOUT);
      end
   endtask

   task automatic read_both(rf_addr_t a, rf_addr_t b);
      re_a    = 1'b1;
      raddr_a = a;
      re_b    = 1'b1;
      raddr_b = b;
      tick();
      re_a = 1'b0;
      re_b = 1'b0;
   endtask

   // Idle cycles so the last read has been checked before the verdict.
   task automatic settle();
      idle_inputs();
      repeat (2) tick();
   endtask

   task automatic finish_test(string name, int errs_before);
      tests_run++;
      if (errors > errs_before) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errs_before);
      end else begin
         $display("test %s: passed", name);
      end
   endtask

   task automatic test_clear(output bit ok);
      int e0;
      e0 = errors;
      apply_reset();
      assert (ready === 1'b0) else begin
         errors++;
         $display("FAILED ready: got %h, expected %h", ready, 1'b0);
      end
      wait_ready(ok);
      if (ok) begin
         for (int i = 0; i < RF_DEPTH; i++) begin
            read_both(rf_addr_t'(i), rf_addr_t'(RF_DEPTH - 1 - i));
         end
      end
      settle();
      finish_test("reset and clear", e0);
   endtask

   // The writes target addresses the sweep has already passed, so a write that
   // got through would not be covered up by a later zero write.
   task automatic test_dropped(output bit ok);
      int e0;
      e0 = errors;
      apply_reset();
      repeat (4) tick();
      for (int i = 1; i <= 8; i++) begin
         we    = 1'b1;
         waddr = rf_addr_t'(i);
         wdata = rand_data() | 32'h1;
         tick();
      end
      idle_inputs();
      wait_ready(ok);
      if (ok) begin
         for (int i = 1; i <= 8; i++) begin
            read_both(rf_addr_t'(i), rf_addr_t'(9 - i));
         end
      end
      settle();
      finish_test("writes dropped during clear", e0);
   endtask

   // Reads often target the last written address, so written words get read.
   task automatic test_random();
      int       e0;
      rf_addr_t last;
      e0   = errors;
      last = '0;
      for (int i = 0; i < RANDOM_OPS; i++) begin
         we      = rand_bit();
         waddr   = rand_addr();
         wdata   = rand_data();
         re_a    = rand_bit();
         raddr_a = rand_bit() ? last : rand_addr();
         re_b    = rand_bit();
         raddr_b = rand_bit() ? last : rand_addr();
         if (we) begin
            last = waddr;
         end
         tick();
         if ((i % 8) == 7) begin
            idle_inputs();
            repeat (3) tick();
         end
      end
      settle();
      finish_test("random write and read", e0);
   endtask

   task automatic test_bypass();
      int       e0;
      rf_addr_t x;
      rf_addr_t y;
      e0 = errors;
      for (int i = 0; i < 8; i++) begin
         x = rand_addr();
         if (x == '0) begin
            x = rf_addr_t'(1);
         end
         y     = x ^ rf_addr_t'(1);
         we    = 1'b1;
         waddr = x;
         wdata = rand_data();
         re_a  = 1'b1;
         re_b  = 1'b1;
         // The colliding read alternates between the two ports.
         raddr_a = ((i % 2) == 1) ? x : y;
         raddr_b = ((i % 2) == 1) ? y : x;
         tick();
         idle_inputs();
         tick();
      end
      settle();
      finish_test("same-edge bypass", e0);
   endtask

   task automatic test_zero();
      int e0;
      e0    = errors;
      we    = 1'b1;
      waddr = '0;
      wdata = rand_data() | 32'h80000000;
      tick();
      idle_inputs();
      read_both('0, '0);
      // Write and read register zero on the same edge.
      we    = 1'b1;
      waddr = '0;
      wdata = rand_data() | 32'h1;
      read_both('0, '0);
      settle();
      finish_test("register zero", e0);
   endtask

   initial begin
      bit ok;
      lfsr         = SEED;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;
      rst          = 1'b1;
      idle_inputs();
      test_clear(ok);
      if (ok) begin
         test_dropped(ok);
      end
      if (ok) begin
         test_random();
         test_bypass();
         test_zero();
      end
      $display("tests run: %0d, tests failed: %0d, value checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule : tb_rf

//--- src.f
rtl/rf_pkg.sv
rtl/rf_dpram.sv
rtl/rf_clear.sv
rtl/rf_bank.sv
rtl/rf_top.sv
tests/tb_clock.sv
tests/tb_rf.sv

//--- Makefile
# Verilator lint, simulation and clean for the register file testbench.

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module tb_rf

# A simulator that exits abnormally also counts as a failed run.
sim:
	verilator --binary --timing --assert -f src.f --top-module tb_rf -Mdir obj_dir
	./obj_dir/Vtb_rf > $(LOG) 2>&1 || echo "Simulation finished: FAIL" >> $(LOG)
	cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
